// File: Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_gb_memory \
		-f flist.f -o Vtb_gb_memory

run: compile
	./obj_dir/Vtb_gb_memory +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: flist.f
src/gb_mem_pkg.sv
src/gb_bus_decoder.sv
src/sync_ram.sv
src/ly_counter.sv
src/read_data_mux.sv
src/gb_memory_top.sv
verification/gb_memory_props.sv
verification/tb_gb_memory.sv

// File: src/gb_bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module gb_bus_decoder import gb_mem_pkg::*; (
   input  wire logic                clock,
   input  wire logic                reset,
   input  wire logic [ADDR_W-1:0]   addr,
   input  wire logic                mem_we,
   input  wire logic                mem_re,
   output logic                     wram_we,
   output logic [WRAM_AW-1:0]       wram_index,
   output logic                     vram_we,
   output logic [VRAM_AW-1:0]       vram_index,
   output logic [FLASH_AW-1:0]      flash_a,
   output region_t                  rd_region,
   output logic                     rd_pending,
   output logic                     audio_we,
   output logic [7:0]               audio_addr
);

   region_t           region;
   logic              is_read;
   logic              audio_hit;
   logic [ADDR_W-1:0] wram_off;
   logic [ADDR_W-1:0] vram_off;
   logic [ADDR_W-1:0] oam_off;

   // address map, first match wins
   always_comb begin
      if (addr <= FLASH_END) begin
         region = REGION_FLASH;
      end else if (addr >= VRAM_START && addr <= VRAM_END) begin
         region = REGION_VRAM;
      end else if (addr >= WRAM_START && addr <= WRAM_END) begin
         region = REGION_WRAM;
      end else if (addr >= OAM_START && addr <= OAM_END) begin
         region = REGION_OAM;
      end else if (addr == LY_ADDR) begin
         region = REGION_LY;
      end else if ((addr >= AUDIO_A_START && addr <= AUDIO_A_END) ||
                   (addr >= AUDIO_B_START && addr <= AUDIO_B_END) ||
                   (addr >= AUDIO_C_START && addr <= AUDIO_C_END)) begin
         region = REGION_AUDIO;
      end else begin
         // timer, dma and unmapped space all land here
         region = REGION_JUNK;
      end
   end

   // a write wins when both strobes are up
   assign is_read = mem_re && !mem_we;
   assign audio_hit = mem_we && (region == REGION_AUDIO);

   assign wram_we = mem_we && (region == REGION_WRAM);
   assign vram_we = mem_we && (region == REGION_VRAM || region == REGION_OAM);

   // rebase into each array
   assign wram_off = addr - WRAM_START;
   assign vram_off = addr - VRAM_START;
   assign oam_off = addr - OAM_START;

   assign wram_index = wram_off[WRAM_AW-1:0];

   // oam entries follow the vram bytes in the shared array
   assign vram_index = (region == REGION_OAM) ? oam_off[VRAM_AW-1:0] + OAM_BASE :
                                                vram_off[VRAM_AW-1:0];

   // read context travels one stage with the ram read
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         rd_pending <= 1'b0;
         rd_region <= REGION_JUNK;
         flash_a <= '0;
         audio_we <= 1'b0;
      end else begin
         rd_pending <= is_read;
         rd_region <= region;
         audio_we <= audio_hit;
         if (is_read && region == REGION_FLASH) begin
            flash_a <= {{(FLASH_AW-ADDR_W){1'b0}}, addr};
         end
      end
   end

   // low byte picks the sound register
   always_ff @(posedge clock) begin
      if (audio_hit) begin
         audio_addr <= addr[7:0];
      end
   end

endmodule

`default_nettype wire

// File: src/gb_mem_pkg.sv
`default_nettype none

package gb_mem_pkg;

   // cpu bus widths
   localparam int ADDR_W = 16;
   localparam int DATA_W = 8;

   // external flash address width
   localparam int FLASH_AW = 24;

   // boot flash sits at the bottom of the map, end inclusive
   localparam logic [ADDR_W-1:0] FLASH_END = 16'h0140;

   localparam logic [ADDR_W-1:0] VRAM_START = 16'h8000;
   localparam logic [ADDR_W-1:0] VRAM_END = 16'h9FFF;

   localparam logic [ADDR_W-1:0] WRAM_START = 16'hC000;
   localparam logic [ADDR_W-1:0] WRAM_END = 16'hDFFF;

   localparam logic [ADDR_W-1:0] OAM_START = 16'hFE00;
   localparam logic [ADDR_W-1:0] OAM_END = 16'hFE9F;

   // scanline register
   localparam logic [ADDR_W-1:0] LY_ADDR = 16'hFF44;

   // sound register windows, write only from this side
   localparam logic [ADDR_W-1:0] AUDIO_A_START = 16'hFF10;
   localparam logic [ADDR_W-1:0] AUDIO_A_END = 16'hFF1E;
   localparam logic [ADDR_W-1:0] AUDIO_B_START = 16'hFF20;
   localparam logic [ADDR_W-1:0] AUDIO_B_END = 16'hFF26;
   localparam logic [ADDR_W-1:0] AUDIO_C_START = 16'hFF30;
   localparam logic [ADDR_W-1:0] AUDIO_C_END = 16'hFF3F;

   // work ram array
   localparam int WRAM_DEPTH = 8192;
   localparam int WRAM_AW = 13;

   // vram with oam appended right after the 8k of vram
   localparam int VRAM_DEPTH = 8352;
   localparam int VRAM_AW = 14;
   localparam logic [VRAM_AW-1:0] OAM_BASE = 14'd8192;

   // line timing in cpu ticks
   localparam int TICK_W = 9;
   localparam int LINE_TICKS = 441;
   localparam int LAST_LINE = 153;

   typedef enum logic [2:0] {
      REGION_FLASH,
      REGION_WRAM,
      REGION_VRAM,
      REGION_OAM,
      REGION_LY,
      REGION_AUDIO,
      REGION_JUNK
   } region_t;

endpackage

`default_nettype wire

// File: src/gb_memory_top.sv
`timescale 1ns/1ps
`default_nettype none

module gb_memory_top import gb_mem_pkg::*; (
   input  wire logic                clock,
   input  wire logic                reset,
   input  wire logic [ADDR_W-1:0]   addr,
   input  wire logic [DATA_W-1:0]   wr_data,
   input  wire logic                mem_we,
   input  wire logic                mem_re,
   input  wire logic                cpu_tick,
   input  wire logic [DATA_W-1:0]   flash_d,
   output logic [DATA_W-1:0]        rd_data,
   output logic                     rd_valid,
   output logic [FLASH_AW-1:0]      flash_a,
   output logic [DATA_W-1:0]        ly,
   output logic                     audio_we,
   output logic [7:0]               audio_addr,
   output logic [DATA_W-1:0]        audio_data
);

   logic               wram_we;
   logic [WRAM_AW-1:0] wram_index;
   logic [DATA_W-1:0]  wram_q;
   logic               vram_we;
   logic [VRAM_AW-1:0] vram_index;
   logic [DATA_W-1:0]  vram_q;
   region_t            rd_region;
   logic               rd_pending;

   gb_bus_decoder i_gb_bus_decoder (
      .clock      (clock),
      .reset      (reset),
      .addr       (addr),
      .mem_we     (mem_we),
      .mem_re     (mem_re),
      .wram_we    (wram_we),
      .wram_index (wram_index),
      .vram_we    (vram_we),
      .vram_index (vram_index),
      .flash_a    (flash_a),
      .rd_region  (rd_region),
      .rd_pending (rd_pending),
      .audio_we   (audio_we),
      .audio_addr (audio_addr)
   );

   sync_ram #(
      .DEPTH (WRAM_DEPTH),
      .AW    (WRAM_AW)
   ) i_wram (
      .clock (clock),
      .we    (wram_we),
      .index (wram_index),
      .wdata (wr_data),
      .q     (wram_q)
   );

   // vram and oam share one array
   sync_ram #(
      .DEPTH (VRAM_DEPTH),
      .AW    (VRAM_AW)
   ) i_vram (
      .clock (clock),
      .we    (vram_we),
      .index (vram_index),
      .wdata (wr_data),
      .q     (vram_q)
   );

   ly_counter i_ly_counter (
      .clock    (clock),
      .reset    (reset),
      .cpu_tick (cpu_tick),
      .ly       (ly)
   );

   read_data_mux i_read_data_mux (
      .clock      (clock),
      .reset      (reset),
      .rd_region  (rd_region),
      .rd_pending (rd_pending),
      .wram_q     (wram_q),
      .vram_q     (vram_q),
      .flash_d    (flash_d),
      .ly         (ly),
      .rd_data    (rd_data),
      .rd_valid   (rd_valid)
   );

   // lines up with audio_we from the decoder
   always_ff @(posedge clock) begin
      if (mem_we) begin
         audio_data <= wr_data;
      end
   end

endmodule

`default_nettype wire

// File: src/ly_counter.sv
`timescale 1ns/1ps
`default_nettype none

module ly_counter import gb_mem_pkg::*; (
   input  wire logic         clock,
   input  wire logic         reset,
   input  wire logic         cpu_tick,
   output logic [DATA_W-1:0] ly
);

   logic [TICK_W-1:0] tick_count;

   // position within the current line
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         tick_count <= '0;
         ly <= '0;
      end else if (cpu_tick) begin
         if (tick_count == TICK_W'(LINE_TICKS - 1)) begin
            tick_count <= '0;
            // last line of the frame goes back to line 0
            if (ly == DATA_W'(LAST_LINE)) begin
               ly <= '0;
            end else begin
               ly <= ly + 8'd1;
            end
         end else begin
            tick_count <= tick_count + 9'd1;
         end
      end
   end

endmodule

`default_nettype wire

// File: src/read_data_mux.sv
`timescale 1ns/1ps
`default_nettype none

module read_data_mux import gb_mem_pkg::*; (
   input  wire logic              clock,
   input  wire logic              reset,
   input  wire region_t           rd_region,
   input  wire logic              rd_pending,
   input  wire logic [DATA_W-1:0] wram_q,
   input  wire logic [DATA_W-1:0] vram_q,
   input  wire logic [DATA_W-1:0] flash_d,
   input  wire logic [DATA_W-1:0] ly,
   output logic [DATA_W-1:0]      rd_data,
   output logic                   rd_valid
);

   logic [DATA_W-1:0] sel_data;

   always_comb begin
      case (rd_region)
         REGION_FLASH: begin
            sel_data = flash_d;
         end
         REGION_WRAM: begin
            sel_data = wram_q;
         end
         // oam lives in the vram array
         REGION_VRAM, REGION_OAM: begin
            sel_data = vram_q;
         end
         REGION_LY: begin
            sel_data = ly;
         end
         default: begin
            // audio is write only, junk reads as zero
            sel_data = '0;
         end
      endcase
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= rd_pending;
      end
   end

   // data holds until the next read completes
   always_ff @(posedge clock) begin
      if (rd_pending) begin
         rd_data <= sel_data;
      end
   end

endmodule

`default_nettype wire

// File: src/sync_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sync_ram #(
   parameter int DEPTH = 8192,
   parameter int AW = 13
) (
   input  wire logic          clock,
   input  wire logic          we,
   input  wire logic [AW-1:0] index,
   input  wire logic [7:0]    wdata,
   output logic [7:0]         q
);

   logic [7:0] mem [DEPTH];

   // read returns the byte stored before this edge
   always_ff @(posedge clock) begin
      if (we) begin
         mem[index] <= wdata;
      end
      q <= mem[index];
   end

endmodule

`default_nettype wire

// File: verification/gb_memory_props.sv
`timescale 1ns/1ps
`default_nettype none

module gb_memory_props import gb_mem_pkg::*; (
   input wire logic                clock,
   input wire logic                reset,
   input wire logic                mem_we,
   input wire logic                mem_re,
   input wire logic                cpu_tick,
   input wire logic                rd_pending,
   input wire logic                rd_valid,
   input wire logic                audio_we,
   input wire logic [FLASH_AW-1:0] flash_a,
   input wire logic [DATA_W-1:0]   ly
);

   int fail_count = 0;

   // everything is cleared one edge into reset
   assert property (@(posedge clock)
      $past(reset) |-> !rd_valid && !audio_we && !rd_pending && flash_a == '0 && ly == '0)
      else begin
         $error("outputs not cleared by reset");
         fail_count++;
      end

   // read pipeline, valid two edges after the accept
   assert property (@(posedge clock) disable iff (reset)
      (mem_re && !mem_we) |-> ##2 rd_valid)
      else begin
         $error("rd_valid missing two cycles after a read");
         fail_count++;
      end

   assert property (@(posedge clock) disable iff (reset)
      rd_valid |-> $past(mem_re && !mem_we, 2))
      else begin
         $error("rd_valid without a matching read");
         fail_count++;
      end

   assert property (@(posedge clock) disable iff (reset) audio_we |-> $past(mem_we))
      else begin
         $error("audio_we without a write");
         fail_count++;
      end

   // ly moves only on a tick and never passes the last line
   assert property (@(posedge clock) disable iff (reset) ly <= DATA_W'(LAST_LINE))
      else begin
         $error("ly beyond last line");
         fail_count++;
      end

   assert property (@(posedge clock) disable iff (reset) ly != $past(ly) |-> $past(cpu_tick))
      else begin
         $error("ly changed without cpu_tick");
         fail_count++;
      end

endmodule

bind gb_memory_top gb_memory_props i_gb_memory_props (
   .clock      (clock),
   .reset      (reset),
   .mem_we     (mem_we),
   .mem_re     (mem_re),
   .cpu_tick   (cpu_tick),
   .rd_pending (rd_pending),
   .rd_valid   (rd_valid),
   .audio_we   (audio_we),
   .flash_a    (flash_a),
   .ly         (ly)
);

`default_nettype wire

// File: verification/tb_gb_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gb_memory;

   localparam int SEED = 78;
   localparam int CLOCK_NS = 4;
   // a full frame with a tick every cycle, plus room for the bus tests
   localparam int FRAME_CYCLES = 441 * 154;
   localparam int BUS_CYCLES = 12000;
   localparam int WATCHDOG_NS = (FRAME_CYCLES + BUS_CYCLES) * CLOCK_NS;

   logic        clock = 1'b0;
   logic        reset;
   logic [15:0] addr;
   logic [7:0]  wr_data;
   logic        mem_we;
   logic        mem_re;
   logic        cpu_tick;
   logic [7:0]  flash_d;
   logic [7:0]  rd_data;
   logic        rd_valid;
   logic [23:0] flash_a;
   logic [7:0]  ly;
   logic        audio_we;
   logic [7:0]  audio_addr;
   logic [7:0]  audio_data;

   // reference model state
   logic [7:0]  wram_ref [8192];
   logic [7:0]  vram_ref [8192];
   logic [7:0]  oam_ref [160];
   logic [7:0]  exp_q [$];
   logic [7:0]  exp_head = 8'h00;
   int          exp_count = 0;
   logic        pop_due = 1'b0;
   logic [8:0]  tick_ref = '0;
   logic [7:0]  ly_ref = '0;
   logic [15:0] last_addr = '0;
   logic [7:0]  last_data = '0;
   logic        last_audio_wr = 1'b0;
   logic        last_flash_rd = 1'b0;
   int          errors = 0;
   int          total_errors;

   gb_memory_top i_gb_memory_top (.*);

   // flash device answers straight from its address pins
   assign flash_d = flash_a[7:0] ^ 8'h5A;

   always #(CLOCK_NS / 2) clock = ~clock;

   function automatic logic is_audio(logic [15:0] a);
      return (a >= 16'hFF10 && a <= 16'hFF1E) || (a >= 16'hFF20 && a <= 16'hFF26) ||
             (a >= 16'hFF30 && a <= 16'hFF3F);
   endfunction

   // line number after one edge of the counter
   function automatic logic [7:0] line_after(logic [8:0] ticks, logic [7:0] line, logic tick);
      if (tick && ticks == 9'd440) begin
         return (line == 8'd153) ? 8'd0 : line + 8'd1;
      end
      return line;
   endfunction

   function automatic logic [7:0] expected_read(logic [15:0] a);
      if (a <= 16'h0140) begin
         return a[7:0] ^ 8'h5A;
      end else if (a >= 16'h8000 && a <= 16'h9FFF) begin
         return vram_ref[a[12:0]];
      end else if (a >= 16'hC000 && a <= 16'hDFFF) begin
         return wram_ref[a[12:0]];
      end else if (a >= 16'hFE00 && a <= 16'hFE9F) begin
         return oam_ref[a[7:0]];
      end else if (a == 16'hFF44) begin
         // ly as it stands after the accepting edge
         return line_after(tick_ref, ly_ref, cpu_tick);
      end
      return 8'h00;
   endfunction

   function automatic void store_ref(logic [15:0] a, logic [7:0] d);
      if (a >= 16'h8000 && a <= 16'h9FFF) begin
         vram_ref[a[12:0]] = d;
      end else if (a >= 16'hC000 && a <= 16'hDFFF) begin
         wram_ref[a[12:0]] = d;
      end else if (a >= 16'hFE00 && a <= 16'hFE9F) begin
         oam_ref[a[7:0]] = d;
      end
   endfunction

   function automatic void refresh_head();
      exp_count = exp_q.size();
      exp_head = (exp_count > 0) ? exp_q[0] : 8'h00;
   endfunction

   task automatic next_cycle();
      @(negedge clock);
      // retire the read that was checked at the last rising edge
      if (pop_due) begin
         void'(exp_q.pop_front());
      end
      pop_due = rd_valid;
      refresh_head();
   endtask

   task automatic write_byte(input logic [15:0] a, input logic [7:0] d);
      next_cycle();
      addr = a;
      wr_data = d;
      mem_we = 1'b1;
      mem_re = 1'b0;
      store_ref(a, d);
   endtask

   task automatic read_byte(input logic [15:0] a);
      next_cycle();
      addr = a;
      mem_we = 1'b0;
      mem_re = 1'b1;
      exp_q.push_back(expected_read(a));
      refresh_head();
   endtask

   task automatic bus_idle(input logic tick);
      next_cycle();
      mem_we = 1'b0;
      mem_re = 1'b0;
      cpu_tick = tick;
   endtask

   task automatic wait_reads_done();
      bus_idle(cpu_tick);
      while (exp_count > 0) begin
         bus_idle(cpu_tick);
      end
   endtask

   task automatic ram_random_pass();
      logic [15:0] addrs [$];
      logic [15:0] a;
      for (int i = 0; i < 96; i++) begin
         a = (i % 2 == 0) ? 16'hC000 : 16'h8000;
         a = a + 16'($urandom_range(0, 8191));
         addrs.push_back(a);
         write_byte(a, 8'($urandom));
      end
      // overwrites, so the last value has to win
      for (int i = 0; i < 24; i++) begin
         write_byte(addrs[i], 8'($urandom));
      end
      foreach (addrs[i]) begin
         read_byte(addrs[i]);
      end
      for (int i = 0; i < 16; i++) begin
         write_byte(addrs[i], 8'($urandom));
         read_byte(addrs[i]);
      end
      wait_reads_done();
   endtask

   task automatic oam_separation();
      for (int k = 0; k < 160; k++) begin
         write_byte(16'hFE00 + 16'(k), 8'(k) ^ 8'hA5);
         write_byte(16'h8000 + 16'(k), 8'($urandom));
      end
      write_byte(16'h9FFF, 8'h3C);
      for (int k = 0; k < 160; k++) begin
         read_byte(16'hFE00 + 16'(k));
         read_byte(16'h8000 + 16'(k));
      end
      read_byte(16'h9FFF);
      wait_reads_done();
   endtask

   task automatic flash_reads();
      write_byte(16'h0100, 8'hFF);
      for (int a = 0; a <= 320; a++) begin
         read_byte(16'(a));
      end
      read_byte(16'h0141);
      wait_reads_done();
   endtask

   task automatic audio_and_junk();
      logic [15:0] junk [12];
      logic [15:0] a;
      junk = '{16'h0141, 16'hA000, 16'hE000, 16'hFEA0, 16'hFF04, 16'hFF0F,
               16'hFF1F, 16'hFF27, 16'hFF40, 16'hFF46, 16'hFF80, 16'hFFFF};
      for (int i = 0; i < 48; i++) begin
         case (i % 3)
            0: a = 16'hFF10 + 16'($urandom_range(0, 14));
            1: a = 16'hFF20 + 16'($urandom_range(0, 6));
            default: a = 16'hFF30 + 16'($urandom_range(0, 15));
         endcase
         write_byte(a, 8'($urandom));
         if (i % 4 == 0) begin
            read_byte(a);
         end
      end
      foreach (junk[i]) begin
         write_byte(junk[i], 8'($urandom));
         read_byte(junk[i]);
      end
      // ly ignores bus writes
      write_byte(16'hFF44, 8'h99);
      read_byte(16'hFF44);
      wait_reads_done();
   endtask

   task automatic ly_frame_sweep();
      bus_idle(1'b1);
      // a read every cycle walks the whole frame and the wrap to line 0
      for (int i = 0; i < FRAME_CYCLES + 600; i++) begin
         read_byte(16'hFF44);
      end
      wait_reads_done();
      bus_idle(1'b0);
   endtask

   always @(posedge clock) begin
      if (reset) begin
         tick_ref <= '0;
         ly_ref <= '0;
      end else if (cpu_tick) begin
         ly_ref <= line_after(tick_ref, ly_ref, 1'b1);
         tick_ref <= (tick_ref == 9'd440) ? 9'd0 : tick_ref + 9'd1;
      end
      last_addr <= addr;
      last_data <= wr_data;
      last_audio_wr <= !reset && mem_we && is_audio(addr);
      last_flash_rd <= !reset && mem_re && !mem_we && addr <= 16'h0140;
   end

   read_data_check: assert property (@(posedge clock) disable iff (reset)
      rd_valid |-> rd_data == exp_head)
      else begin
         errors++;
         $display("[ERROR] %0t rd_data expected %02h actual %02h", $time,
                  $sampled(exp_head), $sampled(rd_data));
      end

   read_owed_check: assert property (@(posedge clock) disable iff (reset)
      rd_valid |-> exp_count > 0)
      else begin
         errors++;
         $display("%0t: rd_valid pulsed with no read outstanding", $time);
      end

   audio_pulse_check: assert property (@(posedge clock) disable iff (reset)
      audio_we == last_audio_wr)
      else begin
         errors++;
         $display("[ERROR] %0t audio_we expected %0b actual %0b", $time,
                  $sampled(last_audio_wr), $sampled(audio_we));
      end

   audio_addr_check: assert property (@(posedge clock) disable iff (reset)
      last_audio_wr |-> audio_addr == last_addr[7:0])
      else begin
         errors++;
         $display("[ERROR] %0t audio_addr expected %02h actual %02h", $time,
                  $sampled(last_addr[7:0]), $sampled(audio_addr));
      end

   audio_data_check: assert property (@(posedge clock) disable iff (reset)
      last_audio_wr |-> audio_data == last_data)
      else begin
         errors++;
         $display("[ERROR] %0t audio_data expected %02h actual %02h", $time,
                  $sampled(last_data), $sampled(audio_data));
      end

   flash_addr_check: assert property (@(posedge clock) disable iff (reset)
      last_flash_rd |-> flash_a == {8'h00, last_addr})
      else begin
         errors++;
         $display("[ERROR] %0t flash_a expected %06h actual %06h", $time,
                  {8'h00, $sampled(last_addr)}, $sampled(flash_a));
      end

   ly_model_check: assert property (@(posedge clock) disable iff (reset) ly == ly_ref)
      else begin
         errors++;
         $display("[ERROR] %0t ly expected %0d actual %0d", $time, $sampled(ly_ref),
                  $sampled(ly));
      end

   initial begin
      reset = 1'b1;
      addr = '0;
      wr_data = '0;
      mem_we = 1'b0;
      mem_re = 1'b0;
      cpu_tick = 1'b0;
      void'($urandom(SEED));
      repeat (3) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
      ram_random_pass();
      oam_separation();
      flash_reads();
      audio_and_junk();
      ly_frame_sweep();
      repeat (4) @(negedge clock);
      total_errors = errors + i_gb_memory_top.i_gb_memory_props.fail_count;
      $display("errors: %0d (data checks %0d, protocol checks %0d)", total_errors, errors,
               i_gb_memory_top.i_gb_memory_props.fail_count);
      if (total_errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(WATCHDOG_NS);
      $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
      $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire
